// File: logic/pkt_pkg.sv
`default_nettype none

package pkt_pkg;

    // channel caches, one byte per channel in every row
    localparam int NUM_CHAN = 8;
    localparam int CACHE_AW = 6;

    // output packet buffer
    localparam int OUT_AW = 10;

    // packet type codes, sent as the low nibble of the header byte
    localparam logic [3:0] BAG_STAT = 4'h1;
    localparam logic [3:0] BAG_DATA = 4'h5;

    localparam int NUM_PKTS = 8;
    localparam int ROWS_PER_PKT = 8;

    // header plus six status bytes
    localparam int STAT_LEN = 7;
    // header, index byte and 64 row bytes
    localparam int DATA_LEN = 2 + ROWS_PER_PKT * NUM_CHAN;
    localparam int RUN_LEN = STAT_LEN + NUM_PKTS * DATA_LEN;

    // apb register map
    localparam int APB_AW = 13;
    localparam logic [APB_AW-1:0] REG_CTRL = 13'h000;
    localparam logic [APB_AW-1:0] REG_STATUS = 13'h004;
    localparam logic [APB_AW-1:0] REG_STAT_LO = 13'h008;
    localparam logic [APB_AW-1:0] REG_STAT_HI = 13'h00C;
    localparam logic [APB_AW-1:0] REG_LEN = 13'h010;
    // byte i of the output buffer sits at BUF_BASE + 4*i
    localparam logic [APB_AW-1:0] BUF_BASE = 13'h1000;

endpackage

`default_nettype wire

// File: logic/cache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
    parameter int AW = 6
) (
    input  wire           clk,
    input  wire           wr_en,
    input  wire  [AW-1:0] wr_addr,
    input  wire  [7:0]    wr_data,
    input  wire  [AW-1:0] rd_addr,
    output logic [7:0]    rd_data
);

    logic [7:0] mem [0:(1<<AW)-1];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, data follows the address by one cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: logic/chan_fill.sv
`timescale 1ns/1ps
`default_nettype none

module chan_fill import pkt_pkg::*; #(
    parameter int CHAN = 0
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 fill_go,
    output logic                fill_done,
    output logic                wr_en,
    output logic [CACHE_AW-1:0] wr_addr,
    output logic [7:0]          wr_data
);

    logic                active;
    logic [CACHE_AW-1:0] cnt;

    assign wr_en = active;
    assign wr_addr = cnt;
    // pattern is the address plus an odd per-channel bias
    assign wr_data = 8'(cnt) + 8'(2 * CHAN + 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            cnt <= '0;
            fill_done <= 1'b0;
        end else if (fill_go) begin
            active <= 1'b1;
            cnt <= '0;
            fill_done <= 1'b0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
            // last address written this cycle
            if (&cnt) begin
                active <= 1'b0;
                fill_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/pkt_seq.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_seq import pkt_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 start,
    input  wire  [NUM_CHAN-1:0] fill_done,
    input  wire                 build_done,
    output logic                busy,
    output logic                done,
    output logic                fill_go,
    output logic                build_go,
    output logic [3:0]          btype,
    output logic [3:0]          data_idx
);

    typedef enum logic [2:0] {
        IDLE,
        FILL,
        STAT,
        DATA,
        FINISH
    } state_t;

    state_t state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            busy <= 1'b0;
            done <= 1'b0;
            fill_go <= 1'b0;
            build_go <= 1'b0;
            btype <= '0;
            data_idx <= '0;
        end else begin
            fill_go <= 1'b0;
            build_go <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        busy <= 1'b1;
                        done <= 1'b0;
                        fill_go <= 1'b1;
                        state <= FILL;
                    end
                end
                FILL: begin
                    // fill_done still shows the previous run while fill_go is out
                    if (!fill_go && (&fill_done)) begin
                        btype <= BAG_STAT;
                        build_go <= 1'b1;
                        state <= STAT;
                    end
                end
                STAT: begin
                    if (build_done) begin
                        btype <= BAG_DATA;
                        data_idx <= '0;
                        build_go <= 1'b1;
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (build_done) begin
                        if (data_idx == 4'(NUM_PKTS - 1)) begin
                            state <= FINISH;
                        end else begin
                            data_idx <= data_idx + 1'b1;
                            build_go <= 1'b1;
                        end
                    end
                end
                FINISH: begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/pkt_build.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_build import pkt_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   build_go,
    input  wire  [3:0]            btype,
    input  wire  [3:0]            data_idx,
    input  wire  [47:0]           stat_word,
    input  wire  [NUM_CHAN*8-1:0] rd_data,
    output logic [CACHE_AW-1:0]   rd_addr,
    output logic                  wr_en,
    output logic [OUT_AW-1:0]     wr_addr,
    output logic [7:0]            wr_data,
    output logic                  build_done,
    output logic [OUT_AW-1:0]     byte_count
);

    typedef enum logic [2:0] {
        B_IDLE,
        B_HDR,
        B_STAT,
        B_IDX,
        B_ROW,
        B_LAST
    } bstate_t;

    bstate_t               state;
    logic                  is_stat;
    logic [3:0]            hdr;
    logic [3:0]            idx;
    // status byte number, or channel within the current row
    logic [2:0]            cnt;
    logic [2:0]            row;
    logic [NUM_CHAN*8-1:0] row_buf;
    logic [OUT_AW-1:0]     ptr;

    assign wr_addr = ptr;
    assign byte_count = ptr;

    // wr_en and wr_data are set one state ahead of the ram write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= B_IDLE;
            is_stat <= 1'b0;
            cnt <= '0;
            row <= '0;
            wr_en <= 1'b0;
            build_done <= 1'b0;
            ptr <= '0;
            rd_addr <= '0;
        end else begin
            wr_en <= 1'b0;
            build_done <= 1'b0;
            if (wr_en) begin
                ptr <= ptr + 1'b1;
            end
            case (state)
                B_IDLE: begin
                    if (build_go) begin
                        is_stat <= (btype == BAG_STAT);
                        rd_addr <= CACHE_AW'(data_idx * ROWS_PER_PKT);
                        // a status packet opens a new run at byte 0
                        if (btype == BAG_STAT) begin
                            ptr <= '0;
                        end
                        state <= B_HDR;
                    end
                end
                B_HDR: begin
                    wr_en <= 1'b1;
                    cnt <= '0;
                    state <= is_stat ? B_STAT : B_IDX;
                end
                B_STAT: begin
                    wr_en <= 1'b1;
                    cnt <= cnt + 1'b1;
                    if (cnt == 3'(STAT_LEN - 2)) begin
                        state <= B_LAST;
                    end
                end
                B_IDX: begin
                    wr_en <= 1'b1;
                    rd_addr <= rd_addr + 1'b1;
                    cnt <= '0;
                    row <= '0;
                    state <= B_ROW;
                end
                B_ROW: begin
                    wr_en <= 1'b1;
                    cnt <= cnt + 1'b1;
                    if (cnt == 3'(NUM_CHAN - 1)) begin
                        if (row == 3'(ROWS_PER_PKT - 1)) begin
                            state <= B_LAST;
                        end else begin
                            row <= row + 1'b1;
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
                B_LAST: begin
                    // final byte is written at the end of this cycle
                    build_done <= 1'b1;
                    state <= B_IDLE;
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    // byte datapath
    always_ff @(posedge clk) begin
        case (state)
            B_IDLE: begin
                if (build_go) begin
                    hdr <= btype;
                    idx <= data_idx;
                end
            end
            B_HDR: wr_data <= {4'h0, hdr};
            // status word goes out most significant byte first
            B_STAT: wr_data <= stat_word[8*(STAT_LEN-2-cnt) +: 8];
            B_IDX: begin
                wr_data <= {4'h0, idx};
                row_buf <= rd_data;
            end
            B_ROW: begin
                wr_data <= row_buf[8*cnt +: 8];
                // next row was addressed while this one was sent
                if (cnt == 3'(NUM_CHAN - 1)) begin
                    row_buf <= rd_data;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs import pkt_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  wire  [APB_AW-1:0] paddr,
    input  wire  [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    input  wire               busy,
    input  wire               done,
    input  wire  [OUT_AW-1:0] byte_count,
    input  wire  [7:0]        buf_rd_data,
    output logic              start,
    output logic [47:0]       stat_word,
    output logic [OUT_AW-1:0] buf_rd_addr
);

    logic        setup;
    logic        access;
    logic        buf_hit;
    logic        rd_buf;
    logic        buf_wait;
    logic [31:0] reg_rdata;

    assign setup = psel && !penable;
    assign access = psel && penable;
    assign buf_hit = (paddr >= BUF_BASE);
    assign rd_buf = access && !pwrite && buf_hit;

    // one wait state on window reads, everything else completes at once
    assign pready = !(rd_buf && !buf_wait);
    assign pslverr = 1'b0;

    always_comb begin
        case (paddr)
            REG_STATUS: reg_rdata = {30'd0, done, busy};
            REG_STAT_LO: reg_rdata = stat_word[31:0];
            REG_STAT_HI: reg_rdata = {16'd0, stat_word[47:32]};
            REG_LEN: reg_rdata = {{(32-OUT_AW){1'b0}}, byte_count};
            default: reg_rdata = '0;
        endcase
    end

    always_comb begin
        if (!(access && !pwrite)) begin
            prdata = '0;
        end else if (buf_hit) begin
            prdata = {24'd0, buf_rd_data};
        end else begin
            prdata = reg_rdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            buf_wait <= 1'b0;
            buf_rd_addr <= '0;
            start <= 1'b0;
            stat_word <= '0;
        end else begin
            buf_wait <= rd_buf && !buf_wait;
            start <= 1'b0;
            // word index into the window
            if (setup) begin
                buf_rd_addr <= paddr[OUT_AW+1:2];
            end
            if (access && pwrite) begin
                case (paddr)
                    REG_CTRL: start <= pwdata[0] && !busy;
                    REG_STAT_LO: stat_word[31:0] <= pwdata;
                    REG_STAT_HI: stat_word[47:32] <= pwdata[15:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/pkt_top.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_top import pkt_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  wire  [APB_AW-1:0] paddr,
    input  wire  [31:0]       pwdata,
    output wire  [31:0]       prdata,
    output wire               pready,
    output wire               pslverr
);

    wire                  start;
    wire                  busy;
    wire                  done;
    wire                  fill_go;
    wire                  build_go;
    wire                  build_done;
    wire [3:0]            btype;
    wire [3:0]            data_idx;
    wire [47:0]           stat_word;
    wire [NUM_CHAN-1:0]   fill_done;
    wire [NUM_CHAN-1:0]   fill_we;
    wire [CACHE_AW-1:0]   fill_addr [NUM_CHAN];
    wire [7:0]            fill_data [NUM_CHAN];
    wire [CACHE_AW-1:0]   cache_rd_addr;
    // channel c sits in byte lane c
    wire [NUM_CHAN*8-1:0] cache_rd_data;
    wire                  out_we;
    wire [OUT_AW-1:0]     out_addr;
    wire [7:0]            out_data;
    wire [OUT_AW-1:0]     byte_count;
    wire [OUT_AW-1:0]     buf_rd_addr;
    wire [7:0]            buf_rd_data;

    apb_regs apb_regs_inst (
        .clk(clk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .busy(busy),
        .done(done),
        .byte_count(byte_count),
        .buf_rd_data(buf_rd_data),
        .start(start),
        .stat_word(stat_word),
        .buf_rd_addr(buf_rd_addr)
    );

    pkt_seq pkt_seq_inst (
        .clk(clk),
        .rst(rst),
        .start(start),
        .fill_done(fill_done),
        .build_done(build_done),
        .busy(busy),
        .done(done),
        .fill_go(fill_go),
        .build_go(build_go),
        .btype(btype),
        .data_idx(data_idx)
    );

    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        chan_fill #(.CHAN(c)) chan_fill_inst (
            .clk(clk),
            .rst(rst),
            .fill_go(fill_go),
            .fill_done(fill_done[c]),
            .wr_en(fill_we[c]),
            .wr_addr(fill_addr[c]),
            .wr_data(fill_data[c])
        );

        cache_ram #(.AW(CACHE_AW)) cache_inst (
            .clk(clk),
            .wr_en(fill_we[c]),
            .wr_addr(fill_addr[c]),
            .wr_data(fill_data[c]),
            .rd_addr(cache_rd_addr),
            .rd_data(cache_rd_data[8*c +: 8])
        );
    end

    pkt_build pkt_build_inst (
        .clk(clk),
        .rst(rst),
        .build_go(build_go),
        .btype(btype),
        .data_idx(data_idx),
        .stat_word(stat_word),
        .rd_data(cache_rd_data),
        .rd_addr(cache_rd_addr),
        .wr_en(out_we),
        .wr_addr(out_addr),
        .wr_data(out_data),
        .build_done(build_done),
        .byte_count(byte_count)
    );

    // output buffer, read side belongs to the apb window
    cache_ram #(.AW(OUT_AW)) out_buf_inst (
        .clk(clk),
        .wr_en(out_we),
        .wr_addr(out_addr),
        .wr_data(out_data),
        .rd_addr(buf_rd_addr),
        .rd_data(buf_rd_data)
    );

endmodule

`default_nettype wire

// File: dv/pkt_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_checker import pkt_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               psel,
    input  wire               penable,
    input  wire               pwrite,
    input  wire  [APB_AW-1:0] paddr,
    input  wire  [31:0]       pwdata,
    input  wire  [31:0]       prdata,
    input  wire               pready,
    input  wire               pslverr,
    // expected value for status and length reads, which depend on run timing
    input  wire  [31:0]       exp_data,
    input  wire  [31:0]       exp_mask,
    output logic [31:0]       err_count,
    output logic [31:0]       read_count
);

    logic [31:0] stat_lo;
    logic [15:0] stat_hi;
    // status word seen by the builder in the current run
    logic [47:0] run_stat;
    logic        running;
    int          stall;
    int          waits;
    logic [31:0] expect_val;

    // output buffer byte i after a complete run
    function automatic logic [7:0] buf_byte(input int i, input logic [47:0] sw);
        int j;
        int k;
        int o;
        int row;
        int chan;
        if (i < STAT_LEN) begin
            if (i == 0) begin
                return {4'h0, BAG_STAT};
            end
            return sw[8*(STAT_LEN-1-i) +: 8];
        end
        j = i - STAT_LEN;
        k = j / DATA_LEN;
        o = j % DATA_LEN;
        if (o == 0) begin
            return {4'h0, BAG_DATA};
        end else if (o == 1) begin
            return 8'(k);
        end
        row = ROWS_PER_PKT * k + (o - 2) / NUM_CHAN;
        chan = (o - 2) % NUM_CHAN;
        return 8'(row + 2 * chan + 1);
    endfunction

    function automatic logic [31:0] predict(input logic [APB_AW-1:0] addr);
        if (addr >= BUF_BASE) begin
            return {24'd0, buf_byte((int'(addr) - int'(BUF_BASE)) / 4, run_stat)};
        end
        case (addr)
            REG_STAT_LO: return stat_lo;
            REG_STAT_HI: return {16'd0, stat_hi};
            REG_STATUS: return exp_data;
            REG_LEN: return exp_data;
            default: return 32'd0;
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            stat_lo <= '0;
            stat_hi <= '0;
            run_stat <= '0;
            running <= 1'b0;
            stall <= 0;
            err_count = 0;
            read_count = 0;
        end else if (psel && penable && !pready) begin
            stall <= stall + 1;
        end else if (psel && penable) begin
            stall <= 0;
            if (pslverr !== 1'b0) begin
                err_count = err_count + 1;
                $display("[FAIL] %0t pslverr expected 0 actual %b", $time, pslverr);
            end
            // window reads take one wait state, everything else none
            waits = (!pwrite && paddr >= BUF_BASE) ? 1 : 0;
            if (stall != waits) begin
                err_count = err_count + 1;
                $display("%0t transfer at 0x%h took %0d wait states instead of %0d",
                         $time, paddr, stall, waits);
            end
            if (pwrite) begin
                case (paddr)
                    REG_STAT_LO: stat_lo <= pwdata;
                    REG_STAT_HI: stat_hi <= pwdata[15:0];
                    REG_CTRL: begin
                        if (pwdata[0] && !running) begin
                            running <= 1'b1;
                            run_stat <= {stat_hi, stat_lo};
                        end
                    end
                    default: ;
                endcase
            end else begin
                read_count = read_count + 1;
                expect_val = predict(paddr);
                if ((prdata & exp_mask) !== (expect_val & exp_mask)) begin
                    err_count = err_count + 1;
                    $display("[FAIL] %0t prdata at 0x%h expected 0x%h actual 0x%h",
                             $time, paddr, expect_val & exp_mask, prdata & exp_mask);
                end
                if (paddr == REG_STATUS && prdata[1:0] == 2'b10) begin
                    running <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/pkt_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pkt_tb import pkt_pkg::*; ();

    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_RAND = 2;
    localparam int OP_POLL = 3;
    localparam int OP_BUF = 4;
    localparam int MAX_STEPS = 64;

    logic              clk;
    logic              rst;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [31:0]       pwdata;
    wire  [31:0]       prdata;
    wire               pready;
    wire               pslverr;
    logic [31:0]       exp_data;
    logic [31:0]       exp_mask;
    wire  [31:0]       err_count;
    wire  [31:0]       read_count;

    // for OP_BUF the address is the first byte and the data the byte count
    int                step_op [MAX_STEPS];
    logic [APB_AW-1:0] step_addr [MAX_STEPS];
    logic [31:0]       step_data [MAX_STEPS];
    logic [31:0]       step_exp [MAX_STEPS];
    logic [31:0]       step_mask [MAX_STEPS];
    int                num_steps;
    int                limit_cycles;
    logic              table_ready;
    logic [31:0]       seed;

    pkt_top pkt_top_inst (
        .clk(clk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr)
    );

    pkt_checker pkt_checker_inst (
        .clk(clk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .exp_data(exp_data),
        .exp_mask(exp_mask),
        .err_count(err_count),
        .read_count(read_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_step(input int op, input logic [APB_AW-1:0] addr,
                            input logic [31:0] data, input logic [31:0] exp,
                            input logic [31:0] mask);
        step_op[num_steps] = op;
        step_addr[num_steps] = addr;
        step_data[num_steps] = data;
        step_exp[num_steps] = exp;
        step_mask[num_steps] = mask;
        num_steps++;
    endtask

    task automatic build_table();
        num_steps = 0;
        // reset values and unmapped space
        add_step(OP_RD, REG_STATUS, 0, 32'h0, '1);
        add_step(OP_RD, REG_LEN, 0, 32'h0, '1);
        add_step(OP_RD, REG_CTRL, 0, 32'h0, '1);
        add_step(OP_RD, 13'h020, 0, 32'h0, '1);
        add_step(OP_RD, 13'h0ffc, 0, 32'h0, '1);
        add_step(OP_WR, REG_STAT_LO, 32'h1234_5678, 0, 0);
        add_step(OP_WR, REG_STAT_HI, 32'hdead_9abc, 0, 0);
        add_step(OP_WR, 13'h024, 32'hffff_ffff, 0, 0);
        add_step(OP_RD, REG_STAT_LO, 0, 0, '1);
        add_step(OP_RD, REG_STAT_HI, 0, 0, '1);
        for (int r = 0; r < 2; r++) begin
            add_step(OP_RAND, 0, 0, 0, 0);
            add_step(OP_RD, REG_STAT_LO, 0, 0, '1);
            add_step(OP_RD, REG_STAT_HI, 0, 0, '1);
            add_step(OP_WR, REG_CTRL, 32'h1, 0, 0);
            add_step(OP_RD, REG_STATUS, 0, 32'h1, '1);
            // second start while the run is busy
            add_step(OP_WR, REG_CTRL, 32'h1, 0, 0);
            add_step(OP_POLL, 0, 0, 0, 0);
            add_step(OP_RD, REG_STATUS, 0, 32'h2, '1);
            add_step(OP_RD, REG_LEN, 0, RUN_LEN, '1);
            add_step(OP_BUF, 0, RUN_LEN, 0, '1);
        end
    endtask

    // one APB transfer that returns the read data of its completing edge
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [31:0] data, input logic [31:0] exp,
                            input logic [31:0] mask, output logic [31:0] rd);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        exp_data <= exp;
        exp_mask <= mask;
        @(posedge clk);
        penable <= 1'b1;
        do begin
            @(posedge clk);
        end while (!pready);
        rd = prdata;
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic run_step(input int i);
        logic [31:0] rd;
        rd = '0;
        case (step_op[i])
            OP_WR: apb_xfer(1'b1, step_addr[i], step_data[i], 0, 0, rd);
            OP_RD: apb_xfer(1'b0, step_addr[i], 0, step_exp[i], step_mask[i], rd);
            OP_RAND: begin
                seed = lcg_next(seed);
                apb_xfer(1'b1, REG_STAT_LO, seed, 0, 0, rd);
                seed = lcg_next(seed);
                apb_xfer(1'b1, REG_STAT_HI, seed, 0, 0, rd);
            end
            OP_POLL: begin
                // busy and done change with run timing, the reserved bits stay 0
                while (!rd[1]) begin
                    apb_xfer(1'b0, REG_STATUS, 0, 0, 32'hffff_fffc, rd);
                end
            end
            OP_BUF: begin
                for (int n = 0; n < int'(step_data[i]); n++) begin
                    apb_xfer(1'b0, APB_AW'(BUF_BASE + 4 * (step_addr[i] + n)), 0, 0,
                             step_mask[i], rd);
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        wait (table_ready);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout after %0d cycles, tests did not finish", limit_cycles);
        $display("reads compared %0d, errors %0d", read_count, err_count);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        exp_data = '0;
        exp_mask = '0;
        seed = 32'h5e23_6215;
        table_ready = 1'b0;
        build_table();
        // reset plus ten cycles per transfer and 2 x 700 per run
        limit_cycles = 16;
        for (int i = 0; i < num_steps; i++) begin
            if (step_op[i] == OP_BUF) begin
                limit_cycles += 10 * int'(step_data[i]);
            end else if (step_op[i] == OP_POLL) begin
                limit_cycles += 2 * 700;
            end else if (step_op[i] == OP_RAND) begin
                limit_cycles += 20;
            end else begin
                limit_cycles += 10;
            end
        end
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < num_steps; i++) begin
            run_step(i);
        end
        repeat (4) @(posedge clk);
        $display("reads compared %0d, errors %0d", read_count, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
logic/pkt_pkg.sv
logic/cache_ram.sv
logic/chan_fill.sv
logic/pkt_seq.sv
logic/pkt_build.sv
logic/apb_regs.sv
logic/pkt_top.sv
dv/pkt_checker.sv
dv/pkt_tb.sv
